/* flist.f */
+incdir+verilog
verilog/slap_video_pkg.sv
verilog/video_regs.sv
verilog/raster_gen.sv
verilog/layer_mixer.sv
verilog/palette_ram.sv
verilog/slap_video_top.sv
sim/tb_slap_video.sv

/* sim/tb_slap_video.sv */
// slap video testbench
// axi register traffic, pixel stimulus and assertion checks on the raster side
`include "slap_video_cfg.svh"

module tb_slap_video import slap_video_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic pixel_clk, RESET_n;
	logic [`AXI_ADDR_W-1:0] s_axi_awaddr_i, s_axi_araddr_i;
	logic [`AXI_DATA_W-1:0] s_axi_wdata_i, s_axi_rdata_o;
	logic s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i, s_axi_arvalid_i, s_axi_rready_i;
	logic s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o, s_axi_arready_o, s_axi_rvalid_o;
	logic [1:0] s_axi_bresp_o, s_axi_rresp_o;
	layer_pixels_t pix_i;
	logic [`HPOS_W-1:0] fg_x_o, bg_x_o;
	logic [`VPOS_W-1:0] fg_y_o, bg_y_o;
	rgb_t rgb_o;
	logic h_sync_o, v_sync_o, h_blank_o, v_blank_o;

	logic [31:0] rng = 32'd12;            // xorshift state
	int err_cnt = 0, blank_err = 0, tests_ok = 0, tests_bad = 0;
	logic flip_s, scroll_en, prio_en;     // shadow settings, check enables
	logic [`HPOS_W-1:0] hscroll_s;
	logic [`VPOS_W-1:0] vscroll_s;
	rgb_t pal_s [`PAL_WORDS];             // shadow palette
	rgb_t exp_d1, exp_d2;                 // expected rgb, two stages behind pix_i
	logic hs_q, vs_q, hb_q, vb_q, hs_seen, hb_seen, vb_seen;
	int hs_gap, vs_gap, vb_gap, hb_run, vs_rises, prio_hits, blank_hits;

	slap_video_top slap_video_top_i (.*);

	always #4 pixel_clk = ~pixel_clk;     // 125 MHz pixel clock

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// fg if low 2 bits set, else sprite if low 4 bits set, else bg
	function automatic rgb_t expect_rgb(input layer_pixels_t p);
		logic [`PIX_W-1:0] code;
		if (p.fg[1:0] != 2'b00)
			code = p.fg;
		else if (p.spr[3:0] != 4'h0)
			code = p.spr;
		else
			code = p.bg;
		return pal_s[code];
	endfunction

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("[FAIL] %0d ns: %s", $time, msg);
	endtask

	task automatic finish_test(input string name, input int n_err);
		if (n_err == 0) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: failed with %0d errors", name, n_err);
		end
	endtask

	// ==========================================================================
	// axi4-lite master, aw and w presented together
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge pixel_clk);
		s_axi_awaddr_i  <= addr;
		s_axi_wdata_i   <= data;
		s_axi_awvalid_i <= 1'b1;
		s_axi_wvalid_i  <= 1'b1;
		s_axi_bready_i  <= 1'b1;
		do @(posedge pixel_clk); while (!(s_axi_awready_o && s_axi_wready_o));
		s_axi_awvalid_i <= 1'b0;
		s_axi_wvalid_i  <= 1'b0;
		do @(posedge pixel_clk); while (!s_axi_bvalid_o);   // bready already high
		resp = s_axi_bresp_o;
		s_axi_bready_i <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge pixel_clk);
		s_axi_araddr_i  <= addr;
		s_axi_arvalid_i <= 1'b1;
		s_axi_rready_i  <= 1'b1;
		do @(posedge pixel_clk); while (!s_axi_arready_o);
		s_axi_arvalid_i <= 1'b0;
		do @(posedge pixel_clk); while (!s_axi_rvalid_o);
		data = s_axi_rdata_o;
		resp = s_axi_rresp_o;
		s_axi_rready_i <= 1'b0;
	endtask

	// random write, read back, compare against the field width
	task automatic check_reg(input logic [11:0] addr, input logic [31:0] mask,
			output logic [31:0] kept);
		logic [31:0] rd;
		logic [1:0] bresp, rresp;
		rng = xorshift32(rng);
		axi_write(addr, rng, bresp);
		axi_read(addr, rd, rresp);
		assert (bresp == `AXI_OKAY && rresp == `AXI_OKAY)
			else flag_error($sformatf("addr %03h resp %0d/%0d, want OKAY", addr, bresp, rresp));
		assert (rd == (rng & mask))
			else flag_error($sformatf("addr %03h read %08h, want %08h", addr, rd, rng & mask));
		kept = rng & mask;
	endtask

	task automatic set_scroll(input logic flip, input logic [8:0] h, input logic [7:0] v);
		logic [1:0] resp;
		scroll_en <= 1'b0;
		axi_write(`REG_CTRL, 32'(flip), resp);
		axi_write(`REG_HSCROLL, 32'(h), resp);
		axi_write(`REG_VSCROLL, 32'(v), resp);
		flip_s    = flip;
		hscroll_s = h;
		vscroll_s = v;
		repeat (2) @(posedge pixel_clk);   // new cfg through the raster register
		scroll_en <= 1'b1;
	endtask

	// ==========================================================================
	// monitors feeding the assertions
	always @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			{hs_q, vs_q, hb_q, vb_q, hs_seen, hb_seen, vb_seen} <= '0;
			{hs_gap, vs_gap, vb_gap, hb_run, vs_rises, prio_hits, blank_hits} <= '0;
		end else begin
			hs_q <= h_sync_o;
			vs_q <= v_sync_o;
			hb_q <= h_blank_o;
			vb_q <= v_blank_o;
			if (h_sync_o && !hs_q) begin   // h_sync rising
				hs_gap  <= 1;
				hs_seen <= 1'b1;
			end else
				hs_gap <= hs_gap + 1;
			if (v_sync_o && !vs_q) begin
				vs_gap   <= 1;
				vs_rises <= vs_rises + 1;
			end else
				vs_gap <= vs_gap + 1;
			if (v_blank_o && !vb_q) begin  // first blanked line
				vb_gap  <= 1;
				vb_seen <= 1'b1;
			end else
				vb_gap <= vb_gap + 1;
			if (!h_blank_o && hb_q) begin  // start of visible run
				hb_run  <= 1;
				hb_seen <= 1'b1;
			end else if (!h_blank_o)
				hb_run <= hb_run + 1;
			exp_d1 <= expect_rgb(pix_i);   // mixer stage
			exp_d2 <= exp_d1;              // palette stage
			if (prio_en && !h_blank_o && !v_blank_o)
				prio_hits <= prio_hits + 1;
			if (h_blank_o || v_blank_o)
				blank_hits <= blank_hits + 1;
		end
	end

	hsync_period_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(h_sync_o && !hs_q && hs_seen) |-> hs_gap == `H_TOTAL)
		else flag_error($sformatf("h_sync period %0d cycles", $sampled(hs_gap)));
	vsync_period_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(v_sync_o && !vs_q && vs_rises > 0) |-> vs_gap == `H_TOTAL * `V_TOTAL)
		else flag_error($sformatf("v_sync period %0d cycles", $sampled(vs_gap)));
	// v_blank starts at line V_ACTIVE, v_sync at line VS_START
	vblank_start_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(v_sync_o && !vs_q && vb_seen) |-> vb_gap == (`VS_START - `V_ACTIVE) * `H_TOTAL)
		else flag_error($sformatf("v_blank led v_sync by %0d cycles", $sampled(vb_gap)));
	hblank_run_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(h_blank_o && !hb_q && hb_seen) |-> hb_run == `H_ACTIVE)
		else flag_error($sformatf("visible run %0d cycles", $sampled(hb_run)));
	hscroll_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		scroll_en |-> `HPOS_W'(bg_x_o - fg_x_o) == hscroll_s)
		else flag_error("bg_x minus fg_x differs from hscroll");
	vscroll_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		scroll_en |-> `VPOS_W'(bg_y_o - fg_y_o) == vscroll_s)
		else flag_error("bg_y minus fg_y differs from vscroll");
	step_up_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(scroll_en && $past(scroll_en) && !flip_s && $past(fg_x_o) < 255)
		|-> fg_x_o == $past(fg_x_o) + 1)
		else flag_error("fg_x did not step up in a visible line");
	step_down_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(scroll_en && $past(scroll_en) && flip_s && $past(fg_x_o) >= 1 && $past(fg_x_o) <= 255)
		|-> fg_x_o == $past(fg_x_o) - 1)
		else flag_error("fg_x did not step down in a flipped line");
	priority_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(prio_en && !h_blank_o && !v_blank_o) |-> rgb_o == exp_d2)
		else flag_error($sformatf("rgb %03h, want %03h", $sampled(rgb_o), $sampled(exp_d2)));
	blank_chk: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(h_blank_o || v_blank_o) |-> rgb_o == '0)
		else begin
			blank_err++;
			flag_error($sformatf("rgb %03h during blanking", $sampled(rgb_o)));
		end

	// ==========================================================================
	// four frames plus bus traffic
	initial begin
		#(4 * `H_TOTAL * `V_TOTAL * 8 + 20000);
		$display("timeout: the tests did not finish within four frames");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] kept, rd;
		logic [1:0] resp, rresp;
		layer_pixels_t pat;
		int e0, target;
		pixel_clk = 1'b0;
		RESET_n   = 1'b0;
		{s_axi_awaddr_i, s_axi_araddr_i, s_axi_wdata_i} = '0;
		{s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i} = '0;
		{s_axi_arvalid_i, s_axi_rready_i} = '0;
		pix_i = '0;
		{scroll_en, prio_en} = '0;
		repeat (8) @(posedge pixel_clk);
		RESET_n <= 1'b1;

		// 1: masked read back, unmapped and palette reads
		e0 = err_cnt;
		check_reg(`REG_CTRL, 32'h1, kept);
		flip_s = kept[0];
		check_reg(`REG_HSCROLL, (32'd1 << `HPOS_W) - 1, kept);
		hscroll_s = kept[`HPOS_W-1:0];
		check_reg(`REG_VSCROLL, (32'd1 << `VPOS_W) - 1, kept);
		vscroll_s = kept[`VPOS_W-1:0];
		axi_write(12'h010, 32'hFFFF_FFFF, resp);
		axi_read(12'h010, rd, rresp);
		assert (resp == `AXI_SLVERR && rresp == `AXI_SLVERR && rd == '0)
			else flag_error($sformatf("unmapped access resp %0d/%0d data %08h", resp, rresp, rd));
		axi_read(`PAL_BASE + 12'h004, rd, rresp);
		assert (rresp == `AXI_OKAY && rd == '0)
			else flag_error($sformatf("palette read resp %0d data %08h", rresp, rd));
		repeat (2) @(posedge pixel_clk);
		scroll_en <= 1'b1;
		finish_test("register access", err_cnt - e0);

		// 2: sync periods and visible run length, two v_sync edges
		e0 = err_cnt;
		while (vs_rises < 2) @(posedge pixel_clk);
		finish_test("raster timing", err_cnt - e0);

		// 3: three lines plain, three lines flipped
		e0 = err_cnt;
		rng = xorshift32(rng);
		set_scroll(1'b0, rng[8:0], rng[23:16]);
		repeat (3 * `H_TOTAL) @(posedge pixel_clk);
		rng = xorshift32(rng);
		set_scroll(1'b1, rng[8:0], rng[23:16]);
		repeat (3 * `H_TOTAL) @(posedge pixel_clk);
		finish_test("scroll and flip", err_cnt - e0);

		// 4: random palette, then one pattern per layer plus random ones
		e0 = err_cnt;
		for (int i = 0; i < `PAL_WORDS; i++) begin
			rng = xorshift32(rng);
			pal_s[i] = rgb_t'(rng[11:0]);
			axi_write(`AXI_ADDR_W'(`PAL_BASE + 4 * i), rng, resp);
			assert (resp == `AXI_OKAY) else flag_error($sformatf("palette write %0d refused", i));
		end
		repeat (3) @(posedge pixel_clk);
		prio_en <= 1'b1;
		for (int p = 0; p < 6; p++) begin
			rng = xorshift32(rng);
			pat = layer_pixels_t'(rng[23:0]);
			if (p == 0) pat.fg[0] = 1'b1;        // fg wins
			if (p == 1) begin                    // sprite wins
				pat.fg[1:0] = 2'b00;
				pat.spr[0]  = 1'b1;
			end
			if (p == 2) begin                    // background shows
				pat.fg[1:0]  = 2'b00;
				pat.spr[3:0] = 4'h0;
			end
			@(posedge pixel_clk);
			pix_i <= pat;
			target = prio_hits + 64;
			while (prio_hits < target) @(posedge pixel_clk);
		end
		prio_en <= 1'b0;
		finish_test("priority", err_cnt - e0);

		// 5: blanking is checked over the whole run
		if (blank_hits == 0)
			flag_error("blanking check never saw a blanked cycle");
		finish_test("blanking", blank_err + (blank_hits == 0));

		$display("%0d tests ok, %0d tests failed, %0d check errors",
			tests_ok, tests_bad, err_cnt);
		if (tests_bad == 0 && err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verilog/layer_mixer.sv */
// layer priority mixer
// foreground over sprites over background, into the colour index
`include "slap_video_cfg.svh"

module layer_mixer import slap_video_pkg::*; (
	input  logic              pixel_clk,
	input  logic              RESET_n,
	input  layer_pixels_t     pix_i,
	input  beam_t             beam_i,
	output logic [`PIX_W-1:0] colour_o,
	output beam_t             beam_o
);

	layer_sel_e        sel;    // winning layer, handy in waves
	logic [`PIX_W-1:0] code;

	// transparency is a zero in the low colour bits
	always_comb begin
		if (pix_i.fg[1:0] != 2'b00)
			sel = FG;
		else if (pix_i.spr[3:0] != 4'b0000)
			sel = SPR;
		else
			sel = BG;
	end

	always_comb begin
		case (sel)
			FG:      code = pix_i.fg;
			SPR:     code = pix_i.spr;
			default: code = pix_i.bg;
		endcase
	end

	// colour register, beam kept in step
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			colour_o <= '0;
			beam_o   <= '0;
		end else begin
			colour_o <= code;
			beam_o   <= beam_i;
		end
	end

endmodule

/* verilog/palette_ram.sv */
// colour palette
// host written 256 x 12 rgb ram, lookup with blanking and output register
`include "slap_video_cfg.svh"

module palette_ram import slap_video_pkg::*; (
	input  logic              pixel_clk,
	input  logic              RESET_n,
	input  pal_wr_t           pal_wr_i,
	input  logic [`PIX_W-1:0] colour_i,
	input  beam_t             beam_i,
	output rgb_t              rgb_o,
	output beam_t             beam_o
);

	rgb_t mem [`PAL_WORDS];   // replaces the three colour proms
	logic blank;

	assign blank = beam_i.h_blank || beam_i.v_blank;

	// host port
	always_ff @(posedge pixel_clk) begin
		if (pal_wr_i.we)
			mem[pal_wr_i.idx] <= pal_wr_i.colour;
	end

	// ==========================================================================
	// pixel port, black outside the active area
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_o  <= '0;
			beam_o <= '0;
		end else begin
			rgb_o  <= blank ? '0 : mem[colour_i];
			beam_o <= beam_i;   // sync stays aligned with rgb
		end
	end

endmodule

/* verilog/raster_gen.sv */
// raster generator
// beam counters, flip mapping, scroll adders, sync and blank
`include "slap_video_cfg.svh"

module raster_gen import slap_video_pkg::*; (
	input  logic               pixel_clk,
	input  logic               RESET_n,
	input  video_cfg_t         cfg_i,
	output beam_t              beam_o,
	output logic [`HPOS_W-1:0] fg_x_o,
	output logic [`VPOS_W-1:0] fg_y_o,
	output logic [`HPOS_W-1:0] bg_x_o,
	output logic [`VPOS_W-1:0] bg_y_o
);

	logic [`HPOS_W-1:0] hcount;
	logic [`VCNT_W-1:0] vcount;
	logic               hwrap, vwrap;
	logic [`HPOS_W-1:0] fg_x;    // screen position after flip
	logic [`VPOS_W-1:0] fg_y;
	beam_t              beam;

	// ==========================================================================
	// beam counters, constant compares in place of the counter proms
	assign hwrap = (hcount == `HPOS_W'(`H_TOTAL - 1));
	assign vwrap = (vcount == `VCNT_W'(`V_TOTAL - 1));

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			hcount <= hwrap ? '0 : hcount + 1'b1;
			if (hwrap)
				vcount <= vwrap ? '0 : vcount + 1'b1;   // line step
		end
	end

	// flip runs x backwards from the last visible pixel
	always_comb begin
		if (cfg_i.flip) begin
			fg_x = `HPOS_W'(`H_ACTIVE - 1) - hcount;   // wraps mod 512
			fg_y = ~vcount[`VPOS_W-1:0];               // 255 - v
		end else begin
			fg_x = hcount;
			fg_y = vcount[`VPOS_W-1:0];
		end
	end

	// window compares
	always_comb begin
		beam.h_sync  = (hcount >= `HPOS_W'(`HS_START)) && (hcount < `HPOS_W'(`HS_END));
		beam.v_sync  = (vcount >= `VCNT_W'(`VS_START)) && (vcount < `VCNT_W'(`VS_END));
		beam.h_blank = (hcount >= `HPOS_W'(`H_ACTIVE));
		beam.v_blank = (vcount >= `VCNT_W'(`V_ACTIVE));
	end

	// ==========================================================================
	// output stage, one clock behind the counters
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			beam_o <= '0;   // what position 0 gives
			fg_x_o <= '0;
			fg_y_o <= '0;
			bg_x_o <= '0;
			bg_y_o <= '0;
		end else begin
			beam_o <= beam;
			fg_x_o <= fg_x;
			fg_y_o <= fg_y;
			bg_x_o <= fg_x + cfg_i.hscroll;   // 9-bit wrap
			bg_y_o <= fg_y + cfg_i.vscroll;   // 8-bit wrap
		end
	end

endmodule

/* verilog/slap_video_cfg.svh */
// slap video configuration
// raster geometry, host register map and bus widths
`ifndef SLAP_VIDEO_CFG_SVH
`define SLAP_VIDEO_CFG_SVH

// ==========================================================================
// raster geometry, in pixel clocks and lines
`define H_TOTAL     384
`define H_ACTIVE    256
`define HS_START    288
`define HS_END      320
`define V_TOTAL     264
`define V_ACTIVE    224
`define VS_START    240
`define VS_END      244
`define HPOS_W      9
`define VPOS_W      8
`define VCNT_W      9     // line counter needs 9 bits for 264 lines

// ==========================================================================
// host register map, byte offsets
`define REG_CTRL    12'h000   // bit 0 screen flip
`define REG_HSCROLL 12'h004
`define REG_VSCROLL 12'h008
`define REG_STATUS  12'h00C   // read only, bit 0 v_blank
`define PAL_BASE    12'h400   // 256 words of 12-bit rgb
`define PAL_MASK    12'h3FF
`define PAL_WORDS   256
`define PIX_W       8         // layer codes and palette index

// bus widths and responses
`define AXI_ADDR_W  12
`define AXI_DATA_W  32
`define AXI_OKAY    2'b00
`define AXI_SLVERR  2'b10

`endif

/* verilog/slap_video_pkg.sv */
// slap video shared types
// settings, beam flags, layer codes and palette writes
`include "slap_video_cfg.svh"

package slap_video_pkg;

	// host settings feeding the raster counters
	typedef struct packed {
		logic               flip;     // screen flip
		logic [`HPOS_W-1:0] hscroll;
		logic [`VPOS_W-1:0] vscroll;
	} video_cfg_t;

	// sync and blank, carried along the pixel pipe
	typedef struct packed {
		logic h_sync;
		logic v_sync;
		logic h_blank;
		logic v_blank;
	} beam_t;

	// codes from the three tile / sprite fetchers
	typedef struct packed {
		logic [`PIX_W-1:0] fg;
		logic [`PIX_W-1:0] spr;
		logic [`PIX_W-1:0] bg;
	} layer_pixels_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// one palette write, single cycle pulse
	typedef struct packed {
		logic              we;
		logic [`PIX_W-1:0] idx;
		rgb_t              colour;
	} pal_wr_t;

	typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_RESP} axi_state_e;
	typedef enum logic [1:0] {FG, SPR, BG} layer_sel_e;

endpackage

/* verilog/slap_video_top.sv */
// slap video top level
// register block beside the raster, mixer and palette pixel path
`include "slap_video_cfg.svh"

module slap_video_top import slap_video_pkg::*; (
	input  logic                   pixel_clk,
	input  logic                   RESET_n,
	input  logic [`AXI_ADDR_W-1:0] s_axi_awaddr_i,
	input  logic                   s_axi_awvalid_i,
	output logic                   s_axi_awready_o,
	input  logic [`AXI_DATA_W-1:0] s_axi_wdata_i,
	input  logic                   s_axi_wvalid_i,
	output logic                   s_axi_wready_o,
	output logic [1:0]             s_axi_bresp_o,
	output logic                   s_axi_bvalid_o,
	input  logic                   s_axi_bready_i,
	input  logic [`AXI_ADDR_W-1:0] s_axi_araddr_i,
	input  logic                   s_axi_arvalid_i,
	output logic                   s_axi_arready_o,
	output logic [`AXI_DATA_W-1:0] s_axi_rdata_o,
	output logic [1:0]             s_axi_rresp_o,
	output logic                   s_axi_rvalid_o,
	input  logic                   s_axi_rready_i,
	input  layer_pixels_t          pix_i,       // from the tile fetchers
	output logic [`HPOS_W-1:0]     fg_x_o,
	output logic [`VPOS_W-1:0]     fg_y_o,
	output logic [`HPOS_W-1:0]     bg_x_o,
	output logic [`VPOS_W-1:0]     bg_y_o,
	output rgb_t                   rgb_o,
	output logic                   h_sync_o,
	output logic                   v_sync_o,
	output logic                   h_blank_o,
	output logic                   v_blank_o
);

	video_cfg_t        cfg;
	pal_wr_t           pal_wr;
	beam_t             raster_beam;   // stage 1, with coordinates
	beam_t             mix_beam;      // stage 2, with colour index
	beam_t             out_beam;      // stage 3, with rgb
	logic [`PIX_W-1:0] colour;

	video_regs video_regs_i (
		.pixel_clk       (pixel_clk),
		.RESET_n         (RESET_n),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.v_blank_i       (raster_beam.v_blank),
		.cfg_o           (cfg),
		.pal_wr_o        (pal_wr)
	);

	raster_gen raster_gen_i (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.cfg_i     (cfg),
		.beam_o    (raster_beam),
		.fg_x_o    (fg_x_o),
		.fg_y_o    (fg_y_o),
		.bg_x_o    (bg_x_o),
		.bg_y_o    (bg_y_o)
	);

	layer_mixer layer_mixer_i (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.pix_i     (pix_i),
		.beam_i    (raster_beam),
		.colour_o  (colour),
		.beam_o    (mix_beam)
	);

	palette_ram palette_ram_i (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.pal_wr_i  (pal_wr),
		.colour_i  (colour),
		.beam_i    (mix_beam),
		.rgb_o     (rgb_o),
		.beam_o    (out_beam)
	);

	// monitor timing, aligned with rgb_o
	assign h_sync_o  = out_beam.h_sync;
	assign v_sync_o  = out_beam.v_sync;
	assign h_blank_o = out_beam.h_blank;
	assign v_blank_o = out_beam.v_blank;

endmodule

/* verilog/video_regs.sv */
// video register block
// axi4-lite slave for scroll, flip, status and palette writes
`include "slap_video_cfg.svh"

module video_regs import slap_video_pkg::*; (
	input  logic                   pixel_clk,
	input  logic                   RESET_n,
	// write address and data
	input  logic [`AXI_ADDR_W-1:0] s_axi_awaddr_i,
	input  logic                   s_axi_awvalid_i,
	output logic                   s_axi_awready_o,
	input  logic [`AXI_DATA_W-1:0] s_axi_wdata_i,
	input  logic                   s_axi_wvalid_i,
	output logic                   s_axi_wready_o,
	output logic [1:0]             s_axi_bresp_o,
	output logic                   s_axi_bvalid_o,
	input  logic                   s_axi_bready_i,
	// read address and data
	input  logic [`AXI_ADDR_W-1:0] s_axi_araddr_i,
	input  logic                   s_axi_arvalid_i,
	output logic                   s_axi_arready_o,
	output logic [`AXI_DATA_W-1:0] s_axi_rdata_o,
	output logic [1:0]             s_axi_rresp_o,
	output logic                   s_axi_rvalid_o,
	input  logic                   s_axi_rready_i,
	input  logic                   v_blank_i,   // from raster, for status
	output video_cfg_t             cfg_o,
	output pal_wr_t                pal_wr_o
);

	axi_state_e             state_q;
	logic                   wr_go, rd_go;      // handshake cycles
	logic                   wr_pal, rd_pal;    // palette window hits
	logic                   wr_mapped, rd_mapped;
	logic [1:0]             resp_q;
	logic [`AXI_DATA_W-1:0] rdata_d, rdata_q;
	video_cfg_t             cfg_q;
	pal_wr_t                pal_q;

	function automatic logic pal_hit(input logic [`AXI_ADDR_W-1:0] addr);
		return (addr & ~`PAL_MASK) == `PAL_BASE;
	endfunction

	// ==========================================================================
	// handshake, one request at a time, write wins a tie
	assign wr_go = (state_q == IDLE) && s_axi_awvalid_i && s_axi_wvalid_i;
	assign rd_go = (state_q == IDLE) && s_axi_arvalid_i && !(s_axi_awvalid_i && s_axi_wvalid_i);

	assign s_axi_awready_o = wr_go;   // aw and w accepted together
	assign s_axi_wready_o  = wr_go;
	assign s_axi_arready_o = rd_go;

	assign wr_pal    = pal_hit(s_axi_awaddr_i);
	assign rd_pal    = pal_hit(s_axi_araddr_i);
	assign wr_mapped = wr_pal ||
		(s_axi_awaddr_i inside {`REG_CTRL, `REG_HSCROLL, `REG_VSCROLL, `REG_STATUS});

	// read mux, fields zero extended
	always_comb begin
		rd_mapped = 1'b1;
		rdata_d   = '0;
		case (s_axi_araddr_i)
			`REG_CTRL:    rdata_d = `AXI_DATA_W'(cfg_q.flip);
			`REG_HSCROLL: rdata_d = `AXI_DATA_W'(cfg_q.hscroll);
			`REG_VSCROLL: rdata_d = `AXI_DATA_W'(cfg_q.vscroll);
			`REG_STATUS:  rdata_d = `AXI_DATA_W'(v_blank_i);
			default:      rd_mapped = rd_pal;   // palette reads as 0, still okay
		endcase
	end

	// ==========================================================================
	// response fsm and settings
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			state_q <= IDLE;
			resp_q  <= `AXI_OKAY;
			rdata_q <= '0;
			cfg_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (wr_go) begin
						state_q <= WRITE_RESP;
						resp_q  <= wr_mapped ? `AXI_OKAY : `AXI_SLVERR;
						case (s_axi_awaddr_i)
							`REG_CTRL:    cfg_q.flip    <= s_axi_wdata_i[0];
							`REG_HSCROLL: cfg_q.hscroll <= s_axi_wdata_i[`HPOS_W-1:0];
							`REG_VSCROLL: cfg_q.vscroll <= s_axi_wdata_i[`VPOS_W-1:0];
							default: ;   // status write dropped, palette below
						endcase
					end else if (rd_go) begin
						state_q <= READ_RESP;
						resp_q  <= rd_mapped ? `AXI_OKAY : `AXI_SLVERR;
						rdata_q <= rdata_d;   // zero on error
					end
				end
				WRITE_RESP: if (s_axi_bready_i) state_q <= IDLE;
				READ_RESP:  if (s_axi_rready_i) state_q <= IDLE;
				default:    state_q <= IDLE;
			endcase
		end
	end

	// palette write pulse, index from word address
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			pal_q <= '0;
		end else begin
			pal_q.we     <= wr_go && wr_pal;
			pal_q.idx    <= s_axi_awaddr_i[9:2];
			pal_q.colour <= rgb_t'(s_axi_wdata_i[11:0]);
		end
	end

	assign s_axi_bvalid_o = (state_q == WRITE_RESP);
	assign s_axi_bresp_o  = resp_q;
	assign s_axi_rvalid_o = (state_q == READ_RESP);
	assign s_axi_rresp_o  = resp_q;
	assign s_axi_rdata_o  = rdata_q;
	assign cfg_o          = cfg_q;
	assign pal_wr_o       = pal_q;

endmodule
